// File: Bender.yml
package:
  name: spram_subsys

sources:
  - spram_pkg.sv
  - sram_macro_model.sv
  - la_spram.sv
  - spram_regs.sv
  - spram_seq.sv
  - spram_subsys.sv
  - target: test
    files:
      - tb_spram_subsys.sv

// File: la_spram.sv
// single port ram wrapper tiling 8 bit macros into byte lanes and address banks
`timescale 1ns/1ps

module la_spram #(
    parameter int DW = 32,                     // memory width
    parameter int AW = 10                      // word address width
) (
    input  logic          clk,                 // memory clock
    input  logic          ce,                  // chip enable
    input  logic          we,                  // write enable
    input  logic [DW-1:0] wmask,               // per bit write mask
    input  logic [AW-1:0] addr,                // word address
    input  logic [DW-1:0] din,                 // write data
    output logic [DW-1:0] dout                 // read data, one cycle after request
);
    import spram_pkg::*;

    localparam int MEM_DEPTH = (AW >= 9) ? 9 : AW;             // deepest macro is 512
    localparam int MEM_BANKS = 2 ** (AW - MEM_DEPTH);          // banks from upper bits
    localparam int LANES     = (DW + MACRO_W - 1) / MACRO_W;   // byte lanes per word
    localparam int PAD_W     = LANES * MACRO_W;                // lane aligned width

    logic [PAD_W-1:0]     din_pad;             // din widened to whole lanes
    logic [PAD_W-1:0]     wmask_pad;           // unused bits never written
    logic [MEM_DEPTH-1:0] mem_addr;            // address inside one macro
    logic [MEM_BANKS-1:0] bank_sel;            // decoded bank of this access
    logic [MEM_BANKS-1:0] bank_sel_q;          // bank of the last read
    logic [PAD_W-1:0]     bank_q [MEM_BANKS];  // raw macro outputs per bank

    always_comb begin
        din_pad            = '0;
        wmask_pad          = '0;  // lanes past DW get a zero mask
        din_pad[DW-1:0]    = din;
        wmask_pad[DW-1:0]  = wmask;
    end

    assign mem_addr = addr[MEM_DEPTH-1:0];

    // bank decode
    if (MEM_BANKS == 1) begin : g_one_bank
        assign bank_sel = 1'b1;  // whole array fits one bank
    end else begin : g_multi_bank
        always_comb begin
            for (int b = 0; b < MEM_BANKS; b++) begin
                bank_sel[b] = (addr[AW-1:MEM_DEPTH] == b);
            end
        end
    end

    // macro Q keeps stale data, so track which bank actually read
    always_ff @(posedge clk) begin
        if (ce && !we) begin
            bank_sel_q <= bank_sel;
        end
    end

    // macro grid, banks by lanes
    for (genvar b = 0; b < MEM_BANKS; b++) begin : g_bank
        logic            bank_ce;  // ce qualified by bank select
        logic            bank_we;  // we qualified by bank select
        wire [PAD_W-1:0] lane_q;   // lane outputs gathered into a word

        assign bank_ce   = ce & bank_sel[b];
        assign bank_we   = we & bank_sel[b];
        assign bank_q[b] = lane_q;

        for (genvar l = 0; l < LANES; l++) begin : g_lane
            sram_macro_model #(
                .DEPTH_BITS (MEM_DEPTH)
            ) u_macro (
                .clk  (clk),
                .cen  (~bank_ce),                             // active low pins
                .gwen (~bank_we),
                .wen  (~wmask_pad[l*MACRO_W +: MACRO_W]),     // 1 in mask means write
                .a    (mem_addr),
                .d    (din_pad[l*MACRO_W +: MACRO_W]),
                .q    (lane_q[l*MACRO_W +: MACRO_W])
            );
        end
    end

    // merge banks, each bit is an OR of gated bank outputs
    always_comb begin
        dout = '0;
        for (int b = 0; b < MEM_BANKS; b++) begin
            dout = dout | (bank_q[b][DW-1:0] & {DW{bank_sel_q[b]}});
        end
    end

endmodule

// File: spram_pkg.sv
// scratchpad subsystem shared sizes, register map, command and sequencer state types
package spram_pkg;

    // datapath sizes
    localparam int DATA_W     = 32;          // memory word width
    localparam int ADDR_W     = 10;          // word address, 1024 words
    localparam int MACRO_W    = 8;           // width of one sram macro
    localparam int REG_ADDR_W = 3;           // host register index width
    localparam int FILL_W     = ADDR_W + 1;  // fill count, covers a full sweep

    // host register map
    typedef enum logic [REG_ADDR_W-1:0] {
        REG_ADDR     = 3'd0,  // word address
        REG_WDATA    = 3'd1,  // write / fill data
        REG_MASK     = 3'd2,  // per bit write mask, 1 writes
        REG_FILL_LEN = 3'd3,  // fill word count
        REG_CMD      = 3'd4,  // command launch, write only
        REG_RDATA    = 3'd5,  // readback, read only
        REG_STATUS   = 3'd6   // bit0 busy, bit1 dropped
    } reg_addr_e;

    // sequencer commands
    typedef enum logic [1:0] {
        CMD_NOP   = 2'd0,  // never launched
        CMD_WRITE = 2'd1,  // single masked write
        CMD_READ  = 2'd2,  // single read into RDATA
        CMD_FILL  = 2'd3   // run of masked writes
    } cmd_e;

    // sequencer FSM states
    typedef enum logic [2:0] {
        S_IDLE      = 3'd0,  // waiting for cmd_start
        S_WRITE     = 3'd1,  // one write cycle
        S_READ      = 3'd2,  // read request out
        S_READ_WAIT = 3'd3,  // macro Q valid this cycle
        S_FILL      = 3'd4   // one word per cycle
    } seq_state_e;

endpackage

// File: spram_regs.sv
// host register block holding operands, launching commands and returning readback and status
`timescale 1ns/1ps

module spram_regs (
    input  logic                           clk,
    input  logic                           reset,       // active high synchronous reset
    // host side
    input  logic                           reg_we,      // register write strobe
    input  logic                           reg_re,      // register read strobe
    input  spram_pkg::reg_addr_e           reg_addr,    // register index
    input  logic [spram_pkg::DATA_W-1:0]   reg_wdata,   // host write data
    output logic [spram_pkg::DATA_W-1:0]   reg_rdata,   // held until next reg_re
    // to sequencer
    output logic                           cmd_start,   // one cycle launch pulse
    output spram_pkg::cmd_e                cmd,         // launched command
    output logic [spram_pkg::ADDR_W-1:0]   addr,        // start word address
    output logic [spram_pkg::DATA_W-1:0]   wdata,       // write / fill data
    output logic [spram_pkg::DATA_W-1:0]   mask,        // per bit write mask
    output logic [spram_pkg::FILL_W-1:0]   fill_len,    // fill word count
    // from sequencer
    input  logic                           busy,        // command in progress
    input  logic                           rd_valid,    // readback strobe
    input  logic [spram_pkg::DATA_W-1:0]   rd_data      // readback word
);
    import spram_pkg::*;

    logic              dropped;    // sticky flag for a cmd that hit a busy sequencer
    logic [DATA_W-1:0] rdata_q;    // RDATA register
    logic              busy_any;   // busy including a launch in flight
    logic              cmd_write;  // host writes CMD this cycle
    cmd_e              cmd_w;      // command field of the host write
    logic [DATA_W-1:0] rd_mux;     // register read mux

    assign busy_any  = busy | cmd_start;  // seq sees cmd_start one edge late
    assign cmd_write = reg_we && (reg_addr == REG_CMD);
    assign cmd_w     = cmd_e'(reg_wdata[$bits(cmd_e)-1:0]);

    // operand registers and command launch
    always_ff @(posedge clk) begin
        if (reset) begin
            addr      <= '0;
            wdata     <= '0;
            mask      <= '0;
            fill_len  <= '0;
            cmd       <= CMD_NOP;
            cmd_start <= 1'b0;
            dropped   <= 1'b0;
        end else begin
            cmd_start <= 1'b0;  // pulse by default
            if (reg_we) begin
                case (reg_addr)
                    REG_ADDR:     addr     <= reg_wdata[ADDR_W-1:0];
                    REG_WDATA:    wdata    <= reg_wdata;
                    REG_MASK:     mask     <= reg_wdata;
                    REG_FILL_LEN: fill_len <= reg_wdata[FILL_W-1:0];
                    REG_STATUS:   dropped  <= 1'b0;  // any write clears
                    default:      ;
                endcase
            end
            if (cmd_write) begin
                if (busy_any) begin
                    dropped <= 1'b1;  // no queueing so flag it
                end else if (cmd_w != CMD_NOP) begin
                    cmd       <= cmd_w;
                    cmd_start <= 1'b1;
                end
            end
        end
    end

    // readback register
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata_q <= '0;
        end else if (rd_valid) begin
            rdata_q <= rd_data;
        end
    end

    // host read mux with undefined slots reading 0
    always_comb begin
        case (reg_addr)
            REG_ADDR:     rd_mux = DATA_W'(addr);
            REG_WDATA:    rd_mux = wdata;
            REG_MASK:     rd_mux = mask;
            REG_FILL_LEN: rd_mux = DATA_W'(fill_len);
            REG_RDATA:    rd_mux = rdata_q;
            REG_STATUS:   rd_mux = DATA_W'({dropped, busy_any});
            default:      rd_mux = '0;  // CMD is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_rdata <= '0;
        end else if (reg_re) begin
            reg_rdata <= rd_mux;  // valid the cycle after the strobe
        end
    end

    // a launch makes the sequencer busy and blocks the next one
    a_start_pulse: assert property (@(posedge clk) disable iff (reset)
        cmd_start |=> (busy && !cmd_start))
        else $error("spram_regs: cmd_start repeated or not taken by the sequencer");

endmodule

// File: spram_seq.sv
// command sequencer driving the memory port for single write, single read and fill
`timescale 1ns/1ps

module spram_seq (
    input  logic                           clk,
    input  logic                           reset,      // active high synchronous reset
    // command side
    input  logic                           cmd_start,  // one cycle launch
    input  spram_pkg::cmd_e                cmd,        // command to run
    input  logic [spram_pkg::ADDR_W-1:0]   addr,       // start address
    input  logic [spram_pkg::DATA_W-1:0]   wdata,      // write / fill data
    input  logic [spram_pkg::DATA_W-1:0]   mask,       // per bit write mask
    input  logic [spram_pkg::FILL_W-1:0]   fill_len,   // words to fill
    output logic                           busy,       // level while running
    output logic                           rd_valid,   // read data this cycle
    output logic [spram_pkg::DATA_W-1:0]   rd_data,    // read word
    // memory port
    output logic                           mem_ce,
    output logic                           mem_we,
    output logic [spram_pkg::DATA_W-1:0]   mem_wmask,
    output logic [spram_pkg::ADDR_W-1:0]   mem_addr,
    output logic [spram_pkg::DATA_W-1:0]   mem_din,
    input  logic [spram_pkg::DATA_W-1:0]   mem_dout
);
    import spram_pkg::*;

    seq_state_e        state;     // FSM state
    logic [FILL_W-1:0] count_q;   // fill words left including current
    logic [ADDR_W-1:0] addr_q;    // current word address
    logic [DATA_W-1:0] wdata_q;   // latched data
    logic [DATA_W-1:0] mask_q;    // latched mask
    logic              launch;    // accepted start

    assign launch = (state == S_IDLE) && cmd_start;

    // FSM and fill counter
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= S_IDLE;
            count_q <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (cmd_start) begin
                        count_q <= fill_len;
                        case (cmd)
                            CMD_WRITE: state <= S_WRITE;
                            CMD_READ:  state <= S_READ;
                            CMD_FILL:  state <= S_FILL;
                            default:   state <= S_IDLE;  // nop does nothing
                        endcase
                    end
                end
                S_WRITE:     state <= S_IDLE;       // single cycle
                S_READ:      state <= S_READ_WAIT;  // macro registers Q
                S_READ_WAIT: state <= S_IDLE;
                S_FILL: begin
                    if (count_q <= FILL_W'(1)) begin
                        state <= S_IDLE;  // last word or empty fill
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
                default:     state <= S_IDLE;
            endcase
        end
    end

    // operands latched at launch and address stepped through a fill
    always_ff @(posedge clk) begin
        if (launch) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            mask_q  <= mask;
        end else if (state == S_FILL) begin
            addr_q <= addr_q + 1'b1;  // wraps at top of array
        end
    end

    // memory port controls
    always_comb begin
        mem_ce = 1'b0;
        mem_we = 1'b0;
        case (state)
            S_WRITE: begin
                mem_ce = 1'b1;
                mem_we = 1'b1;
            end
            S_READ:  mem_ce = 1'b1;  // request with data next cycle
            S_FILL: begin
                mem_ce = (count_q != '0);  // zero length writes nothing
                mem_we = (count_q != '0);
            end
            default: ;
        endcase
    end

    assign mem_addr  = addr_q;
    assign mem_din   = wdata_q;
    assign mem_wmask = mask_q;

    assign busy     = (state != S_IDLE);
    assign rd_valid = (state == S_READ_WAIT);  // RDATA loads at the next edge
    assign rd_data  = mem_dout;

    // a write needs the enable and a known mask
    a_we_needs_ce: assert property (@(posedge clk) disable iff (reset)
        mem_we |-> (mem_ce && !$isunknown(mem_wmask)))
        else $error("spram_seq: mem_we without mem_ce or with an unknown mask");

endmodule

// File: spram_subsys.f
spram_pkg.sv
sram_macro_model.sv
la_spram.sv
spram_regs.sv
spram_seq.sv
spram_subsys.sv
tb_spram_subsys.sv

// File: spram_subsys.sv
// scratchpad subsystem top joining host registers, sequencer and memory array
`timescale 1ns/1ps

module spram_subsys (
    input  logic                           clk,
    input  logic                           reset,      // sync, active high
    input  logic                           reg_we,     // host register write
    input  logic                           reg_re,     // host register read
    input  spram_pkg::reg_addr_e           reg_addr,   // host register index
    input  logic [spram_pkg::DATA_W-1:0]   reg_wdata,  // host write data
    output logic [spram_pkg::DATA_W-1:0]   reg_rdata   // host read data
);
    import spram_pkg::*;

    // registers to sequencer
    logic              cmd_start;
    cmd_e              cmd;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] mask;
    logic [FILL_W-1:0] fill_len;
    logic              busy;
    logic              rd_valid;
    logic [DATA_W-1:0] rd_data;

    // sequencer to memory
    logic              mem_ce;
    logic              mem_we;
    logic [DATA_W-1:0] mem_wmask;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_din;
    logic [DATA_W-1:0] mem_dout;

    spram_regs u_regs (
        .clk       (clk),
        .reset     (reset),
        .reg_we    (reg_we),
        .reg_re    (reg_re),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .addr      (addr),
        .wdata     (wdata),
        .mask      (mask),
        .fill_len  (fill_len),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data)
    );

    spram_seq u_seq (
        .clk       (clk),
        .reset     (reset),
        .cmd_start (cmd_start),
        .cmd       (cmd),
        .addr      (addr),
        .wdata     (wdata),
        .mask      (mask),
        .fill_len  (fill_len),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .mem_ce    (mem_ce),
        .mem_we    (mem_we),
        .mem_wmask (mem_wmask),
        .mem_addr  (mem_addr),
        .mem_din   (mem_din),
        .mem_dout  (mem_dout)
    );

    la_spram #(
        .DW (DATA_W),
        .AW (ADDR_W)
    ) u_mem (
        .clk   (clk),
        .ce    (mem_ce),
        .we    (mem_we),
        .wmask (mem_wmask),
        .addr  (mem_addr),
        .din   (mem_din),
        .dout  (mem_dout)
    );

endmodule

// File: sram_macro_model.sv
// behavioural model of one 8 bit wide single port sram macro with active low controls
`timescale 1ns/1ps

module sram_macro_model #(
    parameter int DEPTH_BITS = 9                     // log2 of macro depth
) (
    input  logic                          clk,
    input  logic                          cen,       // chip enable, active low
    input  logic                          gwen,      // global write enable, active low
    input  logic [spram_pkg::MACRO_W-1:0] wen,       // bit write enable, active low
    input  logic [DEPTH_BITS-1:0]         a,         // macro address
    input  logic [spram_pkg::MACRO_W-1:0] d,         // write data
    output logic [spram_pkg::MACRO_W-1:0] q          // registered read data
);
    import spram_pkg::*;

    localparam int DEPTH = 2 ** DEPTH_BITS;

    logic [MACRO_W-1:0] mem [DEPTH];  // storage array

    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!gwen) begin
                // only bits with wen low take new data
                mem[a] <= (mem[a] & wen) | (d & ~wen);
            end else begin
                q <= mem[a];  // read path, the only place q updates
            end
        end
    end

    // an enabled macro must see a clean address
    a_addr_known: assert property (@(posedge clk) !cen |-> !$isunknown(a))
        else $error("sram_macro_model: address has X while enabled");

endmodule

// File: tb_spram_subsys.sv
// testbench for the scratchpad subsystem checking an op table against a reference memory model
`timescale 1ns/1ps

module tb_spram_subsys;
    import spram_pkg::*;

    localparam int CLK_PERIOD = 10;            // ns
    localparam int MAX_FILL   = 1024;          // longest fill in the table
    localparam int WORDS      = 2 ** ADDR_W;   // array depth

    typedef enum {K_CMD, K_DROP, K_STATUS, K_CLEAR} op_kind_e;  // table entry kinds

    typedef struct {
        op_kind_e          kind;
        cmd_e              cmd;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] mask;
        logic [FILL_W-1:0] len;
        bit                no_wait;   // launch without waiting for idle before a drop
        logic [DATA_W-1:0] exp;       // expected readback
    } op_t;

    logic              clk;
    logic              reset;
    logic              reg_we;
    logic              reg_re;
    reg_addr_e         reg_addr;
    logic [DATA_W-1:0] reg_wdata;
    logic [DATA_W-1:0] reg_rdata;

    op_t               ops[$];            // stimulus table
    logic [DATA_W-1:0] ref_mem [WORDS];   // mirror of the array
    logic [DATA_W-1:0] last_rd = '0;      // what RDATA should hold
    logic [31:0]       rng     = 32'h80de;
    bit                table_built = 0;

    spram_subsys UUT (
        .clk       (clk),
        .reset     (reset),
        .reg_we    (reg_we),
        .reg_re    (reg_re),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // push one entry and apply its effect to the reference model
    task automatic add_op(input op_kind_e kind, input cmd_e cmd, input int addr,
                          input logic [DATA_W-1:0] data, input logic [DATA_W-1:0] mask,
                          input int len, input bit no_wait);
        op_t               op;
        logic [ADDR_W-1:0] a;
        op.kind    = kind;
        op.cmd     = cmd;
        op.addr    = ADDR_W'(addr);
        op.data    = data;
        op.mask    = mask;
        op.len     = FILL_W'(len);
        op.no_wait = no_wait;
        op.exp     = '0;
        a          = op.addr;
        if (kind == K_CMD) begin
            case (cmd)
                CMD_WRITE: ref_mem[a] = (ref_mem[a] & ~mask) | (data & mask);
                CMD_FILL: begin
                    for (int i = 0; i < len; i++) begin
                        ref_mem[a] = (ref_mem[a] & ~mask) | (data & mask);
                        a = a + 1'b1;  // wraps past the top word
                    end
                end
                CMD_READ: begin
                    op.exp  = ref_mem[a];
                    last_rd = op.exp;
                end
                default: ;
            endcase
        end else if (kind == K_STATUS) begin
            op.exp = last_rd;  // RDATA keeps the last readback
        end
        ops.push_back(op);  // K_DROP leaves the model alone
    endtask

    task automatic build_table();
        add_op(K_STATUS, CMD_NOP, 0, '0, '0, 0, 0);              // reset state
        add_op(K_CMD, CMD_FILL, 0, next_rand(), '1, WORDS, 0);   // known contents everywhere
        add_op(K_CMD, CMD_WRITE, 511, next_rand(), '1, 0, 0);    // top of bank 0
        add_op(K_CMD, CMD_WRITE, 512, next_rand(), '1, 0, 0);    // bottom of bank 1
        add_op(K_CMD, CMD_READ, 511, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 512, '0, '0, 0, 0);
        add_op(K_CMD, CMD_WRITE, 0, next_rand(), '1, 0, 0);
        add_op(K_CMD, CMD_WRITE, 1023, next_rand(), '1, 0, 0);
        add_op(K_CMD, CMD_READ, 0, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 1023, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 511, '0, '0, 0, 0);              // same macro row in bank 0
        add_op(K_CMD, CMD_WRITE, 100, next_rand(), next_rand(), 0, 0);  // masked write in bank 0
        add_op(K_CMD, CMD_READ, 100, '0, '0, 0, 0);
        add_op(K_CMD, CMD_WRITE, 700, next_rand(), next_rand(), 0, 0);  // masked write in bank 1
        add_op(K_CMD, CMD_READ, 700, '0, '0, 0, 0);
        add_op(K_CMD, CMD_FILL, 300, next_rand(), next_rand(), 8, 0);
        add_op(K_CMD, CMD_READ, 299, '0, '0, 0, 0);              // neighbour below
        add_op(K_CMD, CMD_READ, 300, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 307, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 308, '0, '0, 0, 0);              // neighbour above
        add_op(K_CMD, CMD_FILL, 1020, next_rand(), '1, 7, 0);    // wraps to word 2
        add_op(K_CMD, CMD_READ, 1019, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 1020, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 1023, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 0, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 2, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 3, '0, '0, 0, 0);
        add_op(K_CMD, CMD_FILL, 50, next_rand(), '1, 0, 0);      // empty fill
        add_op(K_CMD, CMD_READ, 50, '0, '0, 0, 0);
        add_op(K_CMD, CMD_FILL, 600, next_rand(), '1, 200, 1);   // long fill without waiting
        add_op(K_DROP, CMD_WRITE, 900, next_rand(), '1, 0, 0);   // lands while busy
        add_op(K_CMD, CMD_READ, 900, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 600, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 799, '0, '0, 0, 0);
        add_op(K_CMD, CMD_READ, 800, '0, '0, 0, 0);
        add_op(K_CLEAR, CMD_NOP, 0, '0, '0, 0, 0);
        add_op(K_STATUS, CMD_NOP, 0, '0, '0, 0, 0);
    endtask

    task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR @%0t: %s got %h expected %h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_status(input logic [DATA_W-1:0] status, input logic exp_busy,
                                input logic exp_dropped, input string what);
        if (status[0] !== exp_busy || status[1] !== exp_dropped) begin
            $display("ERROR @%0t: %s busy %b dropped %b, expected busy %b dropped %b",
                     $time, what, status[0], status[1], exp_busy, exp_dropped);
            $display("RESULT: FAIL");
            $fatal(1, "status mismatch");
        end
    endtask

    task automatic reg_write(input reg_addr_e a, input logic [DATA_W-1:0] d);
        @(posedge clk);
        reg_we    <= 1'b1;
        reg_addr  <= a;
        reg_wdata <= d;
        @(posedge clk);
        reg_we    <= 1'b0;  // sampled high on this edge
    endtask

    task automatic reg_read(input reg_addr_e a, output logic [DATA_W-1:0] value);
        @(posedge clk);
        reg_re   <= 1'b1;
        reg_addr <= a;
        @(posedge clk);
        reg_re   <= 1'b0;
        @(negedge clk);
        value = reg_rdata;  // settled after the capture edge
    endtask

    task automatic wait_idle();
        logic [DATA_W-1:0] st;
        do begin
            reg_read(REG_STATUS, st);
        end while (st[0] !== 1'b0);
    endtask

    task automatic run_op(input op_t op);
        logic [DATA_W-1:0] rd;
        case (op.kind)
            K_CMD: begin
                reg_write(REG_ADDR, DATA_W'(op.addr));
                reg_write(REG_WDATA, op.data);
                reg_write(REG_MASK, op.mask);
                reg_write(REG_FILL_LEN, DATA_W'(op.len));
                reg_write(REG_CMD, DATA_W'(op.cmd));
                if (!op.no_wait) begin
                    wait_idle();
                    if (op.cmd == CMD_READ) begin
                        reg_read(REG_RDATA, rd);
                        check_word(rd, op.exp, $sformatf("read of word %0d", op.addr));
                    end
                end
            end
            K_DROP: begin
                reg_write(REG_ADDR, DATA_W'(op.addr));
                reg_write(REG_WDATA, op.data);
                reg_write(REG_MASK, op.mask);
                reg_write(REG_CMD, DATA_W'(op.cmd));
                reg_read(REG_STATUS, rd);
                check_status(rd, 1'b1, 1'b1, "command during fill");
                wait_idle();
            end
            K_CLEAR: begin
                reg_write(REG_STATUS, '0);
                reg_read(REG_STATUS, rd);
                check_status(rd, 1'b0, 1'b0, "status after clear");
            end
            default: begin
                reg_read(REG_STATUS, rd);
                check_status(rd, 1'b0, 1'b0, "idle status");
                reg_read(REG_RDATA, rd);
                check_word(rd, op.exp, "RDATA register");
            end
        endcase
    endtask

    // watchdog sized from the table
    initial begin
        wait (table_built);
        #(ops.size() * (MAX_FILL + 20) * CLK_PERIOD);
        $display("Simulation timed out before the op table finished");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        reset     = 1'b1;
        reg_we    = 1'b0;
        reg_re    = 1'b0;
        reg_addr  = REG_ADDR;
        reg_wdata = '0;
        build_table();
        table_built = 1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        foreach (ops[i]) begin
            run_op(ops[i]);
        end
        $display("RESULT: PASS");
        $finish;
    end

endmodule
